//--- gzip_stored_top.f
+incdir+.
deflate_pkg.sv
word_fifo.sv
crc32_byte.sv
bit_packer.sv
stored_block_ctrl.sv
gzip_stored_top.sv
tb_gzip_stored.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_gzip_stored
FILELIST  := gzip_stored_top.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- tb_gzip_model.svh
/*
 * Reference model for the stored-mode GZIP testbench, included into the testbench top.
 * Builds the input word stream and the expected output words, and holds the compare tasks.
 */
`ifndef TB_GZIP_MODEL_SVH
`define TB_GZIP_MODEL_SVH

	word_t rng_state;       // Xorshift state, seeded once at the start
	word_t stim_words[$];   // Header and data words for the input FIFO
	byte_t data_bytes[$];   // Payload bytes only, the CRC runs over these
	byte_t exp_bytes[$];    // Expected deflate body and GZIP trailer
	word_t exp_words[$];    // The same bytes packed low byte first
	word_t exp_isize;       // Sum of all LENs modulo 2**32

	function automatic word_t xorshift32();
		word_t x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Random LEN in lo..hi, bumped off a multiple of 4 when asked
	function automatic len_t random_len(input int lo, input int hi, input logic not_mult4);
		int v;
		v = lo + int'(xorshift32() % 32'(hi - lo + 1));
		if (not_mult4 && (v % 4 == 0)) v = v + 1;
		return len_t'(v);
	endfunction

	task automatic start_stream();
		stim_words.delete();
		data_bytes.delete();
		exp_bytes.delete();
		exp_words.delete();
		exp_isize = '0;
	endtask

	task automatic add_block(input len_t len, input logic bfinal);
		word_t w;
		w = '0;
		stim_words.push_back({7'b0, bfinal, 8'h00, len});  // BFINAL sits at bit 24
		exp_bytes.push_back({7'b0, bfinal});               // BTYPE 00 and pad bits are zero
		exp_bytes.push_back(len[7:0]);
		exp_bytes.push_back(len[15:8]);
		exp_bytes.push_back(~len[7:0]);
		exp_bytes.push_back(~len[15:8]);
		for (int i = 0; i < int'(len); i++) begin
			// Each data word is fully random, so unused upper lanes carry garbage
			if (i % 4 == 0) begin
				w = xorshift32();
				stim_words.push_back(w);
			end
			data_bytes.push_back(w[8*(i%4) +: 8]);
			exp_bytes.push_back(w[8*(i%4) +: 8]);
		end
		exp_isize = exp_isize + word_t'(len);
	endtask

	// Bitwise reflected CRC32, one input bit at a time
	function automatic word_t ref_crc32();
		word_t crc;
		logic  fb;
		crc = 32'hFFFF_FFFF;
		foreach (data_bytes[n]) begin
			for (int b = 0; b < 8; b++) begin
				fb  = crc[0] ^ data_bytes[n][b];
				crc = crc >> 1;
				if (fb) crc = crc ^ 32'hEDB8_8320;
			end
		end
		return ~crc;
	endfunction

	task automatic finish_stream();
		word_t crc;
		word_t w;
		crc = ref_crc32();
		for (int i = 0; i < 4; i++) exp_bytes.push_back(crc[8*i +: 8]);
		for (int i = 0; i < 4; i++) exp_bytes.push_back(exp_isize[8*i +: 8]);
		w = '0;
		foreach (exp_bytes[n]) begin
			w[8*(n%4) +: 8] = exp_bytes[n];
			if (n % 4 == 3) begin
				exp_words.push_back(w);
				w = '0;
			end
		end
		if (exp_bytes.size() % 4 != 0) exp_words.push_back(w);  // Zero-padded last word
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

`endif

//--- tb_gzip_stored.sv
/*
 * Testbench for the stored-mode GZIP engine with a small FIFO depth.
 * Runs several random streams, each after its own reset, and compares every output word.
 */
`timescale 1ns/10ps

module tb_gzip_stored
	import deflate_pkg::*;
;

	localparam int TIMEOUT_CYCLES = 2000;  // Limit for every wait loop

	logic  clk;
	logic  rst_n;
	logic  in_wr_en;
	word_t in_data;
	logic  in_full;
	logic  out_rd_en;
	word_t out_data;
	logic  out_empty;
	logic  done;

	// Prints the error and ends the run with a failing status
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

`include "tb_gzip_model.svh"

	gzip_stored_top #(.FIFO_DEPTH_LOG(4)) UUT (
		.clk, .rst_n,
		.in_wr_en, .in_data, .in_full,
		.out_rd_en, .out_data, .out_empty,
		.done
	);

	always #10 clk = ~clk;  // 20 ns period

	// ======================================================================
	// Reset, input writes and output drain
	// ======================================================================
	task automatic apply_reset();
		@(posedge clk);
		rst_n     <= 1'b0;
		in_wr_en  <= 1'b0;
		in_data   <= '0;
		out_rd_en <= 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_flag(done, 1'b0, "done after reset");
		check_flag(out_empty, 1'b1, "out_empty after reset");
		check_flag(in_full, 1'b0, "in_full after reset");
	endtask

	task automatic push_stream();
		int waited;
		foreach (stim_words[n]) begin
			waited = 0;
			@(negedge clk);
			while (in_full) begin  // Host never writes into a full FIFO
				waited++;
				if (waited > TIMEOUT_CYCLES) abort_run("Timeout: input FIFO stayed full");
				@(negedge clk);
			end
			@(posedge clk);
			in_wr_en <= 1'b1;
			in_data  <= stim_words[n];
			@(posedge clk);
			in_wr_en <= 1'b0;
		end
	endtask

	task automatic drain_output(input logic hold_first, input int max_gap);
		int idx;
		int quiet;
		int waited;
		int gap;
		idx    = 0;
		quiet  = 0;
		waited = 0;
		// Hold off reads until the output has sat still for 50 cycles
		while (hold_first && (quiet < 50)) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES) abort_run("Timeout: output never settled while stalled");
			if (out_empty || UUT.word_valid) quiet = 0;
			else quiet++;
			check_flag(done, 1'b0, "done while the output is stalled");
		end
		waited = 0;
		while (idx < exp_words.size()) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES) abort_run("Timeout: expected output word never arrived");
			if (!out_empty) begin
				check_word(out_data, exp_words[idx], $sformatf("output word %0d", idx));
				idx++;
				@(posedge clk);
				out_rd_en <= 1'b1;
				@(posedge clk);
				out_rd_en <= 1'b0;
				gap = int'(xorshift32() % 32'(max_gap + 1));
				repeat (gap) @(posedge clk);  // Random pause between reads
			end
		end
	endtask

	// One stream in and out, then nothing more may show up
	task automatic run_stream(input logic hold_first, input int max_gap);
		fork
			push_stream();
			drain_output(hold_first, max_gap);
		join
		@(negedge clk);
		check_flag(done, 1'b1, "done after the drain");
		repeat (4) @(negedge clk);
		check_flag(out_empty, 1'b1, "out_empty after the last word");
	endtask

	// ======================================================================
	// Scenarios
	// ======================================================================
	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		in_wr_en  = 1'b0;
		in_data   = '0;
		out_rd_en = 1'b0;
		rng_state = 32'hc491_604f;

		// Single final block of random size
		apply_reset();
		start_stream();
		add_block(random_len(1, 40, 1'b0), 1'b1);
		finish_stream();
		run_stream(1'b0, 3);

		// Three blocks with odd tails, only the last one final
		apply_reset();
		start_stream();
		add_block(random_len(1, 40, 1'b1), 1'b0);
		add_block(random_len(1, 40, 1'b1), 1'b0);
		add_block(random_len(1, 40, 1'b1), 1'b1);
		finish_stream();
		run_stream(1'b0, 2);

		// An empty stored block in the middle of the stream
		apply_reset();
		start_stream();
		add_block(random_len(1, 40, 1'b0), 1'b0);
		add_block(16'd0, 1'b0);
		add_block(random_len(1, 40, 1'b0), 1'b1);
		finish_stream();
		run_stream(1'b0, 1);

		// Output FIFO fills up before the host starts reading
		apply_reset();
		start_stream();
		add_block(16'd60, 1'b1);
		finish_stream();
		run_stream(1'b1, 5);

		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- gzip_stored_top.sv
/*
 * Top level of the stored-mode deflate/GZIP engine.
 * The host writes block headers and data words in, and reads the packed deflate body out.
 */
`timescale 1ns/10ps

module gzip_stored_top
	import deflate_pkg::*;
#(
	parameter int FIFO_DEPTH_LOG = 9  // Depth of both FIFOs as a power of two
) (
	input  logic  clk,
	input  logic  rst_n,
	// Host write side
	input  logic  in_wr_en,
	input  word_t in_data,
	output logic  in_full,
	// Host read side
	input  logic  out_rd_en,
	output word_t out_data,
	output logic  out_empty,
	output logic  done
);

	word_t       in_rd_data;
	logic        in_empty;
	logic        in_rd_en;
	logic        out_almost_full;
	logic        field_valid;
	field_size_t field_size;
	word_t       field_data;
	logic        field_last;
	logic        crc_valid;
	byte_t       crc_byte;
	word_t       crc_value;
	logic        word_valid;
	word_t       word_data;

	// ======================================================================
	// Input FIFO, controller and CRC
	// ======================================================================
	word_fifo #(.DEPTH_LOG(FIFO_DEPTH_LOG)) in_fifo (
		.clk, .rst_n,
		.wr_en(in_wr_en), .wr_data(in_data),
		.rd_en(in_rd_en), .rd_data(in_rd_data),
		.full(in_full), .almost_full(), .empty(in_empty)
	);

	stored_block_ctrl ctrl (
		.clk, .rst_n,
		.in_rd_data, .in_empty, .in_rd_en,
		.out_almost_full,
		.field_valid, .field_size, .field_data, .field_last,
		.crc_valid, .crc_byte, .crc_value,
		.done
	);

	crc32_byte crc (.clk, .rst_n, .crc_valid, .crc_byte, .crc_value);

	// ======================================================================
	// Packer and output FIFO
	// ======================================================================
	bit_packer packer (
		.clk, .rst_n,
		.field_valid, .field_size, .field_data, .field_last,
		.word_valid, .word_data
	);

	// The controller stalls on almost_full, so a packer write never meets a full FIFO
	word_fifo #(.DEPTH_LOG(FIFO_DEPTH_LOG)) out_fifo (
		.clk, .rst_n,
		.wr_en(word_valid), .wr_data(word_data),
		.rd_en(out_rd_en), .rd_data(out_data),
		.full(), .almost_full(out_almost_full), .empty(out_empty)
	);

endmodule

//--- stored_block_ctrl.sv
/*
 * Controller for stored deflate blocks and the GZIP trailer.
 * Parses block header words, walks the data bytes and feeds one field per cycle to the packer.
 */
`timescale 1ns/10ps

module stored_block_ctrl
	import deflate_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	// Input FIFO side
	input  word_t       in_rd_data,
	input  logic        in_empty,
	output logic        in_rd_en,
	// Output FIFO back-pressure
	input  logic        out_almost_full,
	// Packer side
	output logic        field_valid,
	output field_size_t field_size,
	output word_t       field_data,
	output logic        field_last,
	// CRC side
	output logic        crc_valid,
	output byte_t       crc_byte,
	input  word_t       crc_value,
	output logic        done
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	len_t        len_r;      // LEN of the current block
	logic        bfinal_r;   // Current block is the last one
	logic [1:0]  byte_idx;   // Byte lane inside the head data word
	len_t        byte_cnt;   // Data bytes already emitted in this block
	word_t       isize_r;    // Running sum of LEN, wraps at 2**32
	logic        flush_cnt;  // Second cycle of FLUSH
	logic        last_byte;  // The byte at byte_idx closes the block
	byte_t       cur_byte;   // Data byte selected from the head word

	// Bytes of a data word are taken low lane first
	assign cur_byte  = in_rd_data[{byte_idx, 3'b000} +: 8];
	assign last_byte = (byte_cnt == (len_r - len_t'(1)));
	assign crc_byte  = cur_byte;  // Only sampled while crc_valid is high

	// ======================================================================
	// Next state and field decode
	// ======================================================================
	always_comb begin
		state_nxt   = state;
		field_valid = 1'b0;
		field_size  = '0;
		field_data  = '0;
		field_last  = 1'b0;
		crc_valid   = 1'b0;
		in_rd_en    = 1'b0;

		case (state)
			IDLE: begin
				// Once done is set the engine stays here until reset
				if (!in_empty && !done) state_nxt = BLOCK_HEADER;
			end

			BLOCK_HEADER: begin
				if (!out_almost_full) begin
					field_valid = 1'b1;
					field_size  = STORED_HEADER_BITS;
					field_data  = {31'b0, in_rd_data[BFINAL_BIT]};  // BTYPE and pad bits stay zero
					in_rd_en    = 1'b1;  // Header word is consumed here
					state_nxt   = BLOCK_LEN;
				end
			end

			BLOCK_LEN: begin
				if (!out_almost_full) begin
					field_valid = 1'b1;
					field_size  = 6'd32;
					field_data  = {~len_r, len_r};  // LEN first, NLEN above it
					state_nxt   = (len_r == '0) ? END_OF_BLOCK : LOAD_BYTE;
				end
			end

			LOAD_BYTE: begin
				// Stall on a missing data word or a nearly full output
				if (!in_empty && !out_almost_full) begin
					field_valid = 1'b1;
					field_size  = 6'd8;
					field_data  = {24'b0, cur_byte};
					crc_valid   = 1'b1;
					in_rd_en    = (byte_idx == 2'd3) || last_byte;  // Unused upper lanes are dropped
					if (last_byte) state_nxt = END_OF_BLOCK;
				end
			end

			END_OF_BLOCK: state_nxt = bfinal_r ? CRC_WAIT : IDLE;

			CRC_WAIT: state_nxt = CRC32;

			CRC32: begin
				if (!out_almost_full) begin
					field_valid = 1'b1;
					field_size  = 6'd32;
					field_data  = crc_value;
					state_nxt   = ISIZE;
				end
			end

			ISIZE: begin
				if (!out_almost_full) begin
					field_valid = 1'b1;
					field_size  = 6'd32;
					field_data  = isize_r;
					field_last  = 1'b1;  // Makes the packer flush its remainder
					state_nxt   = FLUSH;
				end
			end

			FLUSH: begin
				// Two cycles cover the last full word and the flushed remainder
				if (flush_cnt) state_nxt = IDLE;
			end

			default: state_nxt = IDLE;
		endcase
	end

	// ======================================================================
	// State, block bookkeeping and done
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			len_r     <= '0;
			bfinal_r  <= 1'b0;
			byte_idx  <= '0;
			byte_cnt  <= '0;
			isize_r   <= '0;
			flush_cnt <= 1'b0;
			done      <= 1'b0;
		end else begin
			state     <= state_nxt;
			flush_cnt <= (state == FLUSH) && !flush_cnt;

			// New block, latch its header and restart the byte walk on lane 0
			if ((state == BLOCK_HEADER) && field_valid) begin
				len_r    <= in_rd_data[15:0];
				bfinal_r <= in_rd_data[BFINAL_BIT];
				isize_r  <= isize_r + word_t'(in_rd_data[15:0]);
				byte_idx <= '0;
				byte_cnt <= '0;
			end

			if ((state == LOAD_BYTE) && field_valid) begin
				byte_idx <= byte_idx + 2'd1;  // Wraps to lane 0 with the next word
				byte_cnt <= byte_cnt + len_t'(1);
			end

			// The packer has written its remainder word by the end of FLUSH
			if ((state == FLUSH) && flush_cnt) done <= 1'b1;
		end
	end

endmodule

//--- bit_packer.sv
/*
 * Packs variable-size bit fields LSB first into 32 bit words for the output FIFO.
 * A field with last set makes the packer flush its zero-padded remainder a cycle later.
 */
`timescale 1ns/10ps

module bit_packer
	import deflate_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        field_valid,
	input  field_size_t field_size,
	input  word_t       field_data,
	input  logic        field_last,
	output logic        word_valid,
	output word_t       word_data
);

	logic [63:0] acc;         // Collected bits, the oldest one sits at bit 0
	logic [6:0]  cnt;         // Valid bits in acc, always below 32 between fields
	logic        flush_pend;  // Last field seen in the previous cycle
	logic [63:0] field_bits;  // Incoming field with bits above field_size cleared
	logic [63:0] merged;      // acc with the current field placed above its bits
	logic [6:0]  cnt_sum;     // Bit count including the current field
	logic        word_done;   // 32 or more bits are present after merging

	// ======================================================================
	// Merge the current field above the bits already held
	// ======================================================================
	always_comb begin
		field_bits = {32'b0, field_data} & ((64'd1 << field_size) - 64'd1);
		merged     = acc;
		cnt_sum    = cnt;
		if (field_valid) begin
			merged  = acc | (field_bits << cnt);  // Up to 31 old bits plus 32 new ones fit in 63
			cnt_sum = cnt + 7'(field_size);
		end
	end

	assign word_done = (cnt_sum >= 7'd32);

	// ======================================================================
	// Word output and remainder flush
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc        <= '0;
			cnt        <= '0;
			flush_pend <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			flush_pend <= field_valid && field_last;
			if (word_done) begin
				word_valid <= 1'b1;
				acc        <= merged >> 32;  // Keep the overflow for the next word
				cnt        <= cnt_sum - 7'd32;
			end else if (flush_pend && (cnt_sum != '0)) begin
				word_valid <= 1'b1;  // Upper bits of the remainder word are already zero
				acc        <= '0;
				cnt        <= '0;
			end else begin
				acc <= merged;
				cnt <= cnt_sum;
			end
		end
	end

	// The low 32 bits go out both for a full word and for a flushed remainder
	always_ff @(posedge clk) begin
		if (word_done || flush_pend) word_data <= merged[31:0];
	end

endmodule

//--- crc32_byte.sv
/*
 * Byte-serial CRC32 accumulator for the GZIP trailer.
 * Folds one data byte per valid cycle, the output is always the finished CRC so far.
 */
`timescale 1ns/10ps

module crc32_byte
	import deflate_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  crc_valid,
	input  byte_t crc_byte,
	output word_t crc_value
);

	word_t crc_reg;  // Running reflected remainder

	// One byte through the reflected polynomial, LSB first
	function automatic word_t crc_fold(input word_t crc, input byte_t data);
		word_t c;
		c = crc ^ {24'b0, data};
		for (int i = 0; i < 8; i++) begin
			// Shift right and subtract the polynomial when a one drops out
			c = c[0] ? ((c >> 1) ^ CRC32_POLY) : (c >> 1);
		end
		return c;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			crc_reg <= CRC32_INIT;  // GZIP starts from all ones
		end else if (crc_valid) begin
			crc_reg <= crc_fold(crc_reg, crc_byte);
		end
	end

	// Final inversion is applied here so the value can be sampled at any time
	assign crc_value = ~crc_reg;

endmodule

//--- word_fifo.sv
/*
 * First-word-fall-through FIFO of 32 bit words with full, almost-full and empty flags.
 * Serves as both the host input FIFO and the output FIFO of the engine.
 */
`timescale 1ns/10ps

module word_fifo
	import deflate_pkg::*;
#(
	parameter int DEPTH_LOG = 9  // FIFO holds 2**DEPTH_LOG words
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  wr_en,
	input  word_t wr_data,
	input  logic  rd_en,
	output word_t rd_data,
	output logic  full,
	output logic  almost_full,
	output logic  empty
);

	localparam int DEPTH = 1 << DEPTH_LOG;

	word_t                mem [DEPTH];  // Storage array
	logic [DEPTH_LOG-1:0] wr_ptr;
	logic [DEPTH_LOG-1:0] rd_ptr;
	logic [DEPTH_LOG:0]   level;        // One bit wider than the pointers so DEPTH fits
	logic                 do_wr;
	logic                 do_rd;

	// Writes into a full FIFO and reads from an empty one are dropped
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_ff @(posedge clk) begin
		if (do_wr) mem[wr_ptr] <= wr_data;
	end

	// Pointers wrap naturally at the power of two depth
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;  // Both or neither leave the level alone
			endcase
		end
	end

	// Head word shows without a read, the read only advances past it
	assign rd_data     = mem[rd_ptr];
	assign empty       = (level == '0);
	assign full        = (level == (DEPTH_LOG + 1)'(DEPTH));
	assign almost_full = (level >= (DEPTH_LOG + 1)'(DEPTH - 2));  // Two or fewer slots left

endmodule

//--- deflate_pkg.sv
/*
 * Shared types and constants for the stored-mode deflate/GZIP engine.
 * Every RTL block pulls what it needs from here by a wildcard import.
 */
package deflate_pkg;

	// ======================================================================
	// Basic data types
	// ======================================================================
	typedef logic [7:0]  byte_t;        // One data byte
	typedef logic [31:0] word_t;        // One host word, also the packer output word
	typedef logic [15:0] len_t;         // Stored block LEN or NLEN
	typedef logic [5:0]  field_size_t;  // Number of valid bits in a packer field, 0..32

	// ======================================================================
	// Stream format constants
	// ======================================================================
	// The header word carries LEN in its low half and BFINAL here
	localparam int unsigned BFINAL_BIT = 24;

	// BFINAL plus BTYPE=00 take three bits, the stored format pads them to a full byte
	localparam field_size_t STORED_HEADER_BITS = 6'd8;

	// Reflected CRC32 as used by GZIP (ISO 3309)
	localparam word_t CRC32_POLY = 32'hEDB8_8320;
	localparam word_t CRC32_INIT = 32'hFFFF_FFFF;  // Also the final XOR value

	// ======================================================================
	// Controller states
	// ======================================================================
	typedef enum logic [3:0] {
		IDLE         = 4'd0,  // Wait for a header word
		BLOCK_HEADER = 4'd1,  // Emit the BFINAL/BTYPE byte and pop the header word
		BLOCK_LEN    = 4'd2,  // Emit LEN and NLEN as one 32 bit field
		LOAD_BYTE    = 4'd3,  // Emit one data byte per cycle
		END_OF_BLOCK = 4'd4,  // Decide between the next block and the trailer
		CRC_WAIT     = 4'd5,  // Let the last data byte settle in the CRC
		CRC32        = 4'd6,  // Emit the finished CRC32
		ISIZE        = 4'd7,  // Emit ISIZE with last set
		FLUSH        = 4'd8   // Give the packer time to write its remainder
	} ctrl_state_t;

endpackage
